/* verilog.f */
hdl/list_cfg_pkg.sv
hdl/list_cmd_pkg.sv
hdl/list_match.sv
hdl/list_update_exe.sv
hdl/list_state.sv
hdl/list_top.sv
bench/list_properties.sv
bench/list_tb.sv

/* Bender.yml */
package:
  name: list_ctx

sources:
  # Packages first, then the RTL from the leaves up
  - hdl/list_cfg_pkg.sv
  - hdl/list_cmd_pkg.sv
  - hdl/list_match.sv
  - hdl/list_update_exe.sv
  - hdl/list_state.sv
  - hdl/list_top.sv
  - target: test
    files:
      - bench/list_properties.sv
      - bench/list_tb.sv

/* bench/list_tb.sv */
//**************************************************
// Testbench with queue model and directed tests
//**************************************************
`timescale 1ns/1ps

module list_tb
  import list_cfg_pkg::*, list_cmd_pkg::*;
();

  // Tests need under 200 cycles, ample margin
  localparam int CYCLE_LIMIT = 2000;

  logic      clk = 1'b0;
  logic      i_reset;
  logic      i_cmd_vld;
  cmd_t      i_cmd;
  key_t      i_key;
  volume_t   i_volume;
  logic      o_notify_vld;
  key_t      o_notify_key;
  volume_t   o_notify_volume;
  logic      o_head_vld;
  key_t      o_head_key;
  volume_t   o_head_volume;
  listsize_t o_listsize;

  // Sorted model of the list
  key_t    m_keys[$];
  volume_t m_vols[$];
  // Command sequence for the burst test
  cmd_t    seq_cmd[$];
  key_t    seq_key[$];
  volume_t seq_vol[$];
  string   cur_test = "reset";
  logic [31:0] rng_state = 32'hf079;
  int      cycle_cnt = 0;

  list_top dut0 (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Run hit the %0d cycle limit without finishing", CYCLE_LIMIT);
      $display("TB FAILED");
      $fatal(1, "Timeout");
    end
  end

  // Bound invariant checker
  always @(dut0.u_props.err_cnt) begin
    if (dut0.u_props.err_cnt != 0) begin
      $display("List invariant assertion failed during test %s", cur_test);
      $display("TB FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_on_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
    $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    $display("TB FAILED");
    $fatal(1, "Mismatch");
  endtask

  // Apply one command to the model, return the expected notify
  task automatic model_apply(input cmd_t c, input key_t k, input volume_t v,
                             output logic nv, output key_t nk, output volume_t nvol);
    int pos;
    int hit;
    nv   = 1'b0;
    nk   = k;
    nvol = '0;
    pos  = 0;
    hit  = -1;
    for (int i = 0; i < m_keys.size(); i++) begin
      if (m_keys[i] < k) pos = i + 1;
      if (m_keys[i] == k) hit = i;
    end
    case (c)
      CMD_CLEAR: begin
        nv = (m_keys.size() != 0);
        nk = '0;
        m_keys.delete();
        m_vols.delete();
      end
      CMD_ADD: begin
        // Full list with every key below is dropped
        if (pos < ENTRIES_N) begin
          m_keys.insert(pos, k);
          m_vols.insert(pos, v);
          if (m_keys.size() > ENTRIES_N) begin
            void'(m_keys.pop_back());
            void'(m_vols.pop_back());
          end
          nv   = (pos == 0);
          nvol = v;
        end
      end
      CMD_DELETE: begin
        if (hit >= 0) begin
          nv   = (hit == 0);
          nvol = m_vols[hit];
          m_keys.delete(hit);
          m_vols.delete(hit);
        end
      end
      default: begin
        if (hit >= 0) begin
          m_vols[hit] = v;
          nv   = (hit == 0);
          nvol = v;
        end
      end
    endcase
  endtask

  // Compare notify, head and size against the model
  task automatic check_result(input logic nv, input key_t nk, input volume_t nvol);
    assert (o_notify_vld === nv) else stop_on_mismatch("notify valid", nv, o_notify_vld);
    if (nv) begin
      assert (o_notify_key === nk) else stop_on_mismatch("notify key", nk, o_notify_key);
      assert (o_notify_volume === nvol)
        else stop_on_mismatch("notify volume", nvol, o_notify_volume);
    end
    assert (o_head_vld === (m_keys.size() != 0))
      else stop_on_mismatch("head valid", m_keys.size() != 0, o_head_vld);
    if (m_keys.size() != 0) begin
      assert (o_head_key === m_keys[0]) else stop_on_mismatch("head key", m_keys[0], o_head_key);
      assert (o_head_volume === m_vols[0])
        else stop_on_mismatch("head volume", m_vols[0], o_head_volume);
    end
    assert (o_listsize === listsize_t'(m_keys.size()))
      else stop_on_mismatch("list size", m_keys.size(), o_listsize);
  endtask

  task automatic drive(input cmd_t c, input key_t k, input volume_t v);
    i_cmd_vld = 1'b1;
    i_cmd     = c;
    i_key     = k;
    i_volume  = v;
  endtask

  // One command, result visible two edges later
  task automatic issue(input cmd_t c, input key_t k, input volume_t v);
    logic    nv;
    key_t    nk;
    volume_t nvol;
    drive(c, k, v);
    @(posedge clk);
    #1;
    i_cmd_vld = 1'b0;
    model_apply(c, k, v, nv, nk, nvol);
    @(posedge clk);
    #1;
    check_result(nv, nk, nvol);
  endtask

  // Sequence on consecutive cycles, each result checked as it lands
  task automatic run_burst();
    logic    nv;
    key_t    nk;
    volume_t nvol;
    for (int n = 0; n < seq_cmd.size(); n++) begin
      drive(seq_cmd[n], seq_key[n], seq_vol[n]);
      @(posedge clk);
      #1;
      if (n > 0) check_result(nv, nk, nvol);
      model_apply(seq_cmd[n], seq_key[n], seq_vol[n], nv, nk, nvol);
    end
    i_cmd_vld = 1'b0;
    @(posedge clk);
    #1;
    check_result(nv, nk, nvol);
  endtask

  task automatic push_cmd(input cmd_t c, input key_t k, input volume_t v);
    seq_cmd.push_back(c);
    seq_key.push_back(k);
    seq_vol.push_back(v);
  endtask

  task automatic test_reset_clear();
    cur_test = "reset_clear";
    check_result(1'b0, '0, '0);
    issue(CMD_CLEAR, 16'h0000, 16'h0000);
  endtask

  task automatic test_add_order();
    cur_test = "add_order";
    for (int i = 4; i >= 1; i--) begin
      issue(CMD_ADD, key_t'(i * 16'h0100), volume_t'(16'h0a00 + i));
    end
    issue(CMD_ADD, 16'h0500, 16'h0a05);
    issue(CMD_ADD, 16'h0600, 16'h0a06);
  endtask

  task automatic test_delete();
    cur_test = "delete";
    issue(CMD_DELETE, 16'h0300, 16'h0000);
    issue(CMD_DELETE, 16'h0100, 16'h0000);
    issue(CMD_DELETE, 16'h0777, 16'h0000);
  endtask

  task automatic test_replace();
    cur_test = "replace";
    issue(CMD_REPLACE, 16'h0200, 16'hbeef);
    issue(CMD_REPLACE, 16'h0500, 16'hcafe);
    issue(CMD_REPLACE, 16'h0999, 16'h1234);
    // Walk 0x500 up to the head to read its new volume
    issue(CMD_DELETE, 16'h0200, 16'h0000);
    issue(CMD_DELETE, 16'h0400, 16'h0000);
  endtask

  task automatic test_full_random();
    key_t k;
    logic dup;
    cur_test = "full_random";
    issue(CMD_CLEAR, 16'h0000, 16'h0000);
    while (m_keys.size() < ENTRIES_N) begin
      rng_state = xorshift32(rng_state);
      k = 16'h1000 + (rng_state[15:0] % 16'he000);
      dup = 1'b0;
      foreach (m_keys[i]) if (m_keys[i] == k) dup = 1'b1;
      if (!dup) issue(CMD_ADD, k, rng_state[31:16]);
    end
    issue(CMD_ADD, 16'hffff, 16'h0f0f);
    issue(CMD_ADD, 16'h0800, 16'h0808);
    while (m_keys.size() > 0) begin
      issue(CMD_DELETE, m_keys[0], 16'h0000);
    end
  endtask

  task automatic test_clear_burst();
    cur_test = "clear_burst";
    for (int i = 1; i <= ENTRIES_N; i++) begin
      issue(CMD_ADD, key_t'(i * 16'h0111), volume_t'(16'h3000 + i));
    end
    issue(CMD_CLEAR, 16'h0000, 16'h0000);
    push_cmd(CMD_ADD, 16'h0300, 16'h1300);
    push_cmd(CMD_ADD, 16'h0100, 16'h1100);
    push_cmd(CMD_ADD, 16'h0200, 16'h1200);
    push_cmd(CMD_REPLACE, 16'h0100, 16'h2100);
    push_cmd(CMD_DELETE, 16'h0100, 16'h0000);
    push_cmd(CMD_REPLACE, 16'h0300, 16'h2300);
    push_cmd(CMD_DELETE, 16'h0300, 16'h0000);
    push_cmd(CMD_ADD, 16'h0050, 16'h1050);
    push_cmd(CMD_CLEAR, 16'h0000, 16'h0000);
    // Spaced first, then the same sequence back to back
    for (int n = 0; n < seq_cmd.size(); n++) begin
      issue(seq_cmd[n], seq_key[n], seq_vol[n]);
    end
    run_burst();
  endtask

  initial begin
    i_reset   = 1'b1;
    i_cmd_vld = 1'b0;
    i_cmd     = CMD_CLEAR;
    i_key     = '0;
    i_volume  = '0;
    repeat (8) @(posedge clk);
    #1;
    i_reset = 1'b0;
    test_reset_clear();
    test_add_order();
    test_delete();
    test_replace();
    test_full_random();
    test_clear_burst();
    $display("TB PASSED");
    $finish;
  end

endmodule

/* bench/list_properties.sv */
//**************************************************
// List invariants, bound into the top level
//**************************************************
`timescale 1ns/1ps

module list_properties
  import list_cfg_pkg::*, list_cmd_pkg::*;
(
  input logic                 clk,
  input logic                 i_reset,
  input logic [ENTRIES_N-1:0] i_stcur_vld,
  input listsize_t            i_stcur_listsize,
  input logic                 i_cmd_vld,
  input logic                 i_notify_vld
);

  // Number of failed assertions so far
  int err_cnt = 0;

  // Valid bits form a run starting at bit 0
  a_vld_contiguous : assert property (@(posedge clk) disable iff (i_reset)
    ((i_stcur_vld + 1'b1) & i_stcur_vld) == {ENTRIES_N{1'b0}})
    else begin
      $error("valid vector is not a contiguous run from bit 0");
      err_cnt++;
    end

  // Entry count tracks the valid vector
  a_size_count : assert property (@(posedge clk) disable iff (i_reset)
    i_stcur_listsize == $countones(i_stcur_vld))
    else begin
      $error("list size differs from the number of valid entries");
      err_cnt++;
    end

  // Two notify cycles in a row need two strobes in a row, two cycles earlier
  a_notify_pulse : assert property (@(posedge clk) disable iff (i_reset)
    i_notify_vld && $past(i_notify_vld) |-> $past(i_cmd_vld, 2) && $past(i_cmd_vld, 3))
    else begin
      $error("notify held high without back to back commands");
      err_cnt++;
    end

endmodule

bind list_top list_properties u_props (
  .clk(clk), .i_reset(i_reset), .i_stcur_vld(stcur_vld),
  .i_stcur_listsize(stcur_listsize), .i_cmd_vld(i_cmd_vld),
  .i_notify_vld(o_notify_vld)
);

/* hdl/list_top.sv */
//**************************************************
// Price list context top level
//**************************************************
`timescale 1ns/1ps

module list_top
  import list_cfg_pkg::*, list_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  // Command
  input  logic      i_cmd_vld,
  input  cmd_t      i_cmd,
  input  key_t      i_key,
  input  volume_t   i_volume,
  // Notify
  output logic      o_notify_vld,
  output key_t      o_notify_key,
  output volume_t   o_notify_volume,
  // Head and entry count
  output logic      o_head_vld,
  output key_t      o_head_key,
  output volume_t   o_head_volume,
  output listsize_t o_listsize
);

  // Command register to update
  logic                    pipe_vld;
  cmd_t                    pipe_cmd;
  key_t                    pipe_key;
  volume_t                 pipe_volume;
  logic                    match_hit;
  logic                    match_full;
  logic [ENTRIES_N-1:0]    match_sel;
  logic [ENTRIES_N-1:0]    mask_cmp;
  // Current state
  logic [ENTRIES_N-1:0]    stcur_vld;
  key_t [ENTRIES_N-1:0]    stcur_keys;
  volume_t [ENTRIES_N-1:0] stcur_volumes;
  listsize_t               stcur_listsize;
  // Next state
  logic [ENTRIES_N-1:0]    stnxt_vld;
  key_t [ENTRIES_N-1:0]    stnxt_keys;
  volume_t [ENTRIES_N-1:0] stnxt_volumes;
  listsize_t               stnxt_listsize;
  logic                    nxt_notify_vld;
  key_t                    nxt_notify_key;
  volume_t                 nxt_notify_volume;

  list_match u_match (
    .clk, .i_reset, .i_cmd_vld, .i_cmd, .i_key, .i_volume,
    .i_stcur_vld(stcur_vld), .i_stcur_keys(stcur_keys),
    .o_pipe_vld(pipe_vld), .o_pipe_cmd(pipe_cmd),
    .o_pipe_key(pipe_key), .o_pipe_volume(pipe_volume),
    .o_match_hit(match_hit), .o_match_full(match_full),
    .o_match_sel(match_sel), .o_mask_cmp(mask_cmp)
  );

  list_update_exe u_update (
    .i_pipe_cmd(pipe_cmd), .i_pipe_key(pipe_key), .i_pipe_volume(pipe_volume),
    .i_match_hit(match_hit), .i_match_full(match_full),
    .i_match_sel(match_sel), .i_mask_cmp(mask_cmp),
    .i_stcur_vld(stcur_vld), .i_stcur_keys(stcur_keys),
    .i_stcur_volumes(stcur_volumes), .i_stcur_listsize(stcur_listsize),
    .o_stnxt_vld(stnxt_vld), .o_stnxt_keys(stnxt_keys),
    .o_stnxt_volumes(stnxt_volumes), .o_stnxt_listsize(stnxt_listsize),
    .o_notify_vld(nxt_notify_vld), .o_notify_key(nxt_notify_key),
    .o_notify_volume(nxt_notify_volume)
  );

  list_state u_state (
    .clk, .i_reset, .i_pipe_vld(pipe_vld),
    .i_stnxt_vld(stnxt_vld), .i_stnxt_keys(stnxt_keys),
    .i_stnxt_volumes(stnxt_volumes), .i_stnxt_listsize(stnxt_listsize),
    .i_notify_vld(nxt_notify_vld), .i_notify_key(nxt_notify_key),
    .i_notify_volume(nxt_notify_volume),
    .o_stcur_vld(stcur_vld), .o_stcur_keys(stcur_keys),
    .o_stcur_volumes(stcur_volumes), .o_stcur_listsize(stcur_listsize),
    .o_notify_vld, .o_notify_key, .o_notify_volume,
    .o_head_vld, .o_head_key, .o_head_volume
  );

  // Entry count straight from the state register
  assign o_listsize = stcur_listsize;

endmodule

/* hdl/list_state.sv */
//**************************************************
// List state registers, notify register, head readout
//**************************************************
`timescale 1ns/1ps

module list_state
  import list_cfg_pkg::*, list_cmd_pkg::*;
(
  input  logic                    clk,
  input  logic                    i_reset,
  // Write enable from the command register
  input  logic                    i_pipe_vld,
  // Next state
  input  logic [ENTRIES_N-1:0]    i_stnxt_vld,
  input  key_t [ENTRIES_N-1:0]    i_stnxt_keys,
  input  volume_t [ENTRIES_N-1:0] i_stnxt_volumes,
  input  listsize_t               i_stnxt_listsize,
  input  logic                    i_notify_vld,
  input  key_t                    i_notify_key,
  input  volume_t                 i_notify_volume,
  // Current state
  output logic [ENTRIES_N-1:0]    o_stcur_vld,
  output key_t [ENTRIES_N-1:0]    o_stcur_keys,
  output volume_t [ENTRIES_N-1:0] o_stcur_volumes,
  output listsize_t               o_stcur_listsize,
  // Notify and head
  output logic                    o_notify_vld,
  output key_t                    o_notify_key,
  output volume_t                 o_notify_volume,
  output logic                    o_head_vld,
  output key_t                    o_head_key,
  output volume_t                 o_head_volume
);

  // Control state, written only while a command is in the pipe
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_stcur_vld      <= '0;
      o_stcur_listsize <= '0;
      o_notify_vld     <= 1'b0;
    end else begin
      // One-cycle pulse per notifying command
      o_notify_vld <= i_pipe_vld & i_notify_vld;
      if (i_pipe_vld) begin
        o_stcur_vld      <= i_stnxt_vld;
        o_stcur_listsize <= i_stnxt_listsize;
      end
    end
  end

  // Entry payload and notify message
  always_ff @(posedge clk) begin
    if (i_pipe_vld) begin
      o_stcur_keys    <= i_stnxt_keys;
      o_stcur_volumes <= i_stnxt_volumes;
      o_notify_key    <= i_notify_key;
      o_notify_volume <= i_notify_volume;
    end
  end

  // Head is entry 0
  assign o_head_vld    = o_stcur_vld[0];
  assign o_head_key    = o_stcur_keys[0];
  assign o_head_volume = o_stcur_volumes[0];

endmodule

/* hdl/list_update_exe.sv */
//**************************************************
// Next list state and head notify generation
//**************************************************
`timescale 1ns/1ps

module list_update_exe
  import list_cfg_pkg::*, list_cmd_pkg::*;
(
  // Registered command and match results
  input  cmd_t                    i_pipe_cmd,
  input  key_t                    i_pipe_key,
  input  volume_t                 i_pipe_volume,
  input  logic                    i_match_hit,
  input  logic                    i_match_full,
  input  logic [ENTRIES_N-1:0]    i_match_sel,
  input  logic [ENTRIES_N-1:0]    i_mask_cmp,
  // Current state
  input  logic [ENTRIES_N-1:0]    i_stcur_vld,
  input  key_t [ENTRIES_N-1:0]    i_stcur_keys,
  input  volume_t [ENTRIES_N-1:0] i_stcur_volumes,
  input  listsize_t               i_stcur_listsize,
  // Next state
  output logic [ENTRIES_N-1:0]    o_stnxt_vld,
  output key_t [ENTRIES_N-1:0]    o_stnxt_keys,
  output volume_t [ENTRIES_N-1:0] o_stnxt_volumes,
  output listsize_t               o_stnxt_listsize,
  // Notify message
  output logic                    o_notify_vld,
  output key_t                    o_notify_key,
  output volume_t                 o_notify_volume
);

  logic op_clr;
  logic op_add;
  logic op_del;
  logic op_rep;
  logic [ENTRIES_N-1:0] add_mask_insert;
  logic [ENTRIES_N-1:0] add_mask_left;
  logic [ENTRIES_N-1:0] add_vld_shift;
  logic [ENTRIES_N-1:0] del_mask_left;
  logic [ENTRIES_N-1:0] mask_right;
  logic [ENTRIES_N-1:0] mask_left;
  logic [ENTRIES_N-1:0] mask_insert_key;
  logic [ENTRIES_N-1:0] mask_insert_vol;
  logic [ENTRIES_N-1:0] vld_nxt;
  key_t    [ENTRIES_N-1:0] key_below;
  key_t    [ENTRIES_N-1:0] key_above;
  volume_t [ENTRIES_N-1:0] vol_below;
  volume_t [ENTRIES_N-1:0] vol_above;
  logic did_clr;
  logic did_add;
  logic did_del;
  logic did_rep;

  // Opcode decode
  assign op_clr = (i_pipe_cmd == CMD_CLEAR);
  assign op_add = (i_pipe_cmd == CMD_ADD);
  assign op_del = (i_pipe_cmd == CMD_DELETE);
  assign op_rep = (i_pipe_cmd == CMD_REPLACE);

  // Insertion point is the lowest clear bit of the compare vector
  // All ones (full, all keys below) gives zero and the ADD is dropped
  assign add_mask_insert = ~i_mask_cmp & (i_mask_cmp + 1'b1);
  // Insertion point and everything above it
  assign add_mask_left = ~(add_mask_insert - 1'b1);
  // Valid entries at or above the insertion point move up one slot
  assign add_vld_shift = (i_stcur_vld & add_mask_left) << 1;

  // Matched entry and everything above it take the entry above
  assign del_mask_left = ~(i_match_sel - 1'b1);

  assign mask_right      = {ENTRIES_N{op_add}} & add_vld_shift;
  assign mask_left       = {ENTRIES_N{op_del}} & del_mask_left;
  assign mask_insert_key = {ENTRIES_N{op_add}} & add_mask_insert;
  // Volume also written in place on REPLACE
  assign mask_insert_vol = mask_insert_key | ({ENTRIES_N{op_rep}} & i_match_sel);

  // Neighbour taps, zero beyond either end of the list
  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_nbr
    if (i == 0) begin : g_lo
      assign key_below[i] = '0;
      assign vol_below[i] = '0;
    end else begin : g_lo
      assign key_below[i] = i_stcur_keys[i-1];
      assign vol_below[i] = i_stcur_volumes[i-1];
    end
    if (i == ENTRIES_N - 1) begin : g_hi
      assign key_above[i] = '0;
      assign vol_above[i] = '0;
    end else begin : g_hi
      assign key_above[i] = i_stcur_keys[i+1];
      assign vol_above[i] = i_stcur_volumes[i+1];
    end
  end

  // Per entry select, masks are disjoint, otherwise hold
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      o_stnxt_keys[i]    = i_stcur_keys[i];
      o_stnxt_volumes[i] = i_stcur_volumes[i];
      if (mask_insert_key[i]) begin
        o_stnxt_keys[i] = i_pipe_key;
      end else if (mask_right[i]) begin
        o_stnxt_keys[i] = key_below[i];
      end else if (mask_left[i]) begin
        o_stnxt_keys[i] = key_above[i];
      end
      if (mask_insert_vol[i]) begin
        o_stnxt_volumes[i] = i_pipe_volume;
      end else if (mask_right[i]) begin
        o_stnxt_volumes[i] = vol_below[i];
      end else if (mask_left[i]) begin
        o_stnxt_volumes[i] = vol_above[i];
      end
    end
  end

  // ADD pushes a one in at bit 0, a full list stays full
  // DELETE hit drops the top bit, REPLACE keeps the vector
  assign vld_nxt = ({ENTRIES_N{op_add}} & {i_stcur_vld[ENTRIES_N-2:0], 1'b1})
                 | ({ENTRIES_N{op_del}} & (i_match_hit ? (i_stcur_vld >> 1) : i_stcur_vld))
                 | ({ENTRIES_N{op_rep}} & i_stcur_vld);
  assign o_stnxt_vld = {ENTRIES_N{~op_clr}} & vld_nxt;

  // Count up unless full, down on a delete hit
  always_comb begin
    o_stnxt_listsize = i_stcur_listsize;
    if (op_clr) begin
      o_stnxt_listsize = '0;
    end else if (op_add && !i_match_full) begin
      o_stnxt_listsize = i_stcur_listsize + 1'b1;
    end else if (op_del && i_match_hit) begin
      o_stnxt_listsize = i_stcur_listsize - 1'b1;
    end
  end

  // Head notify rules
  assign did_clr = op_clr & i_stcur_vld[0];
  assign did_add = op_add & add_mask_insert[0];
  assign did_del = op_del & i_match_sel[0];
  assign did_rep = op_rep & i_match_sel[0];

  assign o_notify_vld = did_clr | did_add | did_del | did_rep;
  // CLEAR reports an empty head
  assign o_notify_key = op_clr ? '0 : i_pipe_key;
  // Removed volume comes from the old head
  assign o_notify_volume = (did_add | did_rep) ? i_pipe_volume :
                           did_del             ? i_stcur_volumes[0] : '0;

endmodule

/* hdl/list_match.sv */
//**************************************************
// Command register with key compare and match logic
//**************************************************
`timescale 1ns/1ps

module list_match
  import list_cfg_pkg::*, list_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_reset,
  // Incoming command strobe
  input  logic                 i_cmd_vld,
  input  cmd_t                 i_cmd,
  input  key_t                 i_key,
  input  volume_t              i_volume,
  // Current list state
  input  logic [ENTRIES_N-1:0] i_stcur_vld,
  input  key_t [ENTRIES_N-1:0] i_stcur_keys,
  // Registered command
  output logic                 o_pipe_vld,
  output cmd_t                 o_pipe_cmd,
  output key_t                 o_pipe_key,
  output volume_t              o_pipe_volume,
  // Match results
  output logic                 o_match_hit,
  output logic                 o_match_full,
  output logic [ENTRIES_N-1:0] o_match_sel,
  output logic [ENTRIES_N-1:0] o_mask_cmp
);

  // Only the strobe is reset, payload follows it
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_pipe_vld <= 1'b0;
    end else begin
      o_pipe_vld <= i_cmd_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (i_cmd_vld) begin
      o_pipe_cmd    <= i_cmd;
      o_pipe_key    <= i_key;
      o_pipe_volume <= i_volume;
    end
  end

  // Per entry compare against the registered key
  // sel is one-hot since keys are unique
  // cmp is a thermometer from bit 0 since the list is sorted
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      o_match_sel[i] = i_stcur_vld[i] & (i_stcur_keys[i] == o_pipe_key);
      o_mask_cmp[i]  = i_stcur_vld[i] & (i_stcur_keys[i] < o_pipe_key);
    end
  end

  // Any entry holding the key
  assign o_match_hit = |o_match_sel;

  // Valid vector is contiguous, so the top bit marks a full list
  assign o_match_full = i_stcur_vld[ENTRIES_N-1];

endmodule

/* hdl/list_cmd_pkg.sv */
//**************************************************
// Command encoding and list payload types
//**************************************************

package list_cmd_pkg;

  import list_cfg_pkg::*;

  // List commands
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Price key
  typedef logic [KEY_BITS-1:0] key_t;

  // Volume at a price
  typedef logic [VOLUME_BITS-1:0] volume_t;

  // Number of valid entries
  typedef logic [LISTSIZE_W-1:0] listsize_t;

endpackage

/* hdl/list_cfg_pkg.sv */
//**************************************************
// Sizing constants of the price list context
//**************************************************

package list_cfg_pkg;

  // Entries held in the context, entry 0 is the head
  localparam int ENTRIES_N = 8;

  // Key width, keys are kept in ascending order
  localparam int KEY_BITS = 16;

  // Volume width carried with each key
  localparam int VOLUME_BITS = 16;

  // Entry count must reach ENTRIES_N
  localparam int LISTSIZE_W = $clog2(ENTRIES_N + 1);

endpackage
